/* all.f */
verilog/cache_pkg.sv
verilog/cache_ctrl.sv
verilog/cache_meta.sv
verilog/cache_data.sv
verilog/blocking_cache.sv
sim/mem_responder.sv
sim/cache_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Build the cache testbench with Verilator, run it, check for the pass message
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module cache_tb -f all.f

out=$(./obj_dir/Vcache_tb)
echo "$out"

if grep -qF "*** TEST PASSED ***" <<< "$out"; then
  exit 0
fi
exit 1

/* sim/cache_tb.sv */
/*
 * Testbench for the blocking cache: random requests over a small
 * address pool, checked against a memory and LRU model
 */
`timescale 1ns/1ps
`default_nettype none

module cache_tb;

  import cache_pkg::*;

  localparam int num_sets = 8;
  localparam int idx_w    = $clog2(num_sets);
  localparam int timeout  = 200;

  logic         clk;
  logic         reset;
  logic         cachereq_val;
  logic         cachereq_rdy;
  cache_req_t   cachereq;
  logic         cacheresp_val;
  logic         cacheresp_rdy;
  cache_resp_t  cacheresp;
  logic         memreq_val;
  logic         memreq_rdy;
  mem_req_t     memreq;
  logic         memresp_val;
  logic         memresp_rdy;
  mem_resp_t    memresp;
  logic         mem_stuck;

  int           seed;
  int           errors;
  logic         timed_out;

  // Reference memory and per-set way state
  logic [DATA_W-1:0] model_mem [logic [ADDR_W-1:0]];
  logic [ADDR_W-1:0] line_m  [2][num_sets];
  logic              valid_m [2][num_sets];
  logic              dirty_m [2][num_sets];
  int                mru_m   [num_sets];
  mem_req_t          memreq_log [$];
  int                memval_total = 0;
  // Memory request sent and its response not yet taken
  logic              mem_waiting = 1'b0;

  blocking_cache #(.num_sets(num_sets)) u_dut (
    .clk           (clk),
    .reset         (reset),
    .cachereq_val  (cachereq_val),
    .cachereq_rdy  (cachereq_rdy),
    .cachereq      (cachereq),
    .cacheresp_val (cacheresp_val),
    .cacheresp_rdy (cacheresp_rdy),
    .cacheresp     (cacheresp),
    .memreq_val    (memreq_val),
    .memreq_rdy    (memreq_rdy),
    .memreq        (memreq),
    .memresp_val   (memresp_val),
    .memresp_rdy   (memresp_rdy),
    .memresp       (memresp)
  );

  mem_responder u_mem (
    .clk         (clk),
    .reset       (reset),
    .memreq_val  (memreq_val),
    .memreq_rdy  (memreq_rdy),
    .memreq      (memreq),
    .memresp_val (memresp_val),
    .memresp_rdy (memresp_rdy),
    .memresp     (memresp),
    .stuck       (mem_stuck)
  );

  always #5 clk = ~clk;

  // Memory port monitor
  always @(negedge clk) begin
    if (!reset) begin
      assert (memresp_rdy == mem_waiting)
        else report_mismatch("mem_port memresp_rdy", LINE_W'(mem_waiting),
                             LINE_W'(memresp_rdy));
      if (memreq_val) begin
        memval_total++;
        if (memreq_rdy) begin
          memreq_log.push_back(memreq);
          mem_waiting = 1'b1;
        end
      end
      if (memresp_val && memresp_rdy) begin
        mem_waiting = 1'b0;
      end
    end
  end

  function automatic int rand_below(input int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  function automatic logic [ADDR_W-1:0] pool_addr(input int set, input int tag, input int word);
    return ADDR_W'(((32'h100 + tag) << (OFFSET_W + idx_w)) | (set << OFFSET_W) | (word << 2));
  endfunction

  function automatic logic [DATA_W-1:0] model_read(input logic [ADDR_W-1:0] addr);
    if (model_mem.exists(addr)) begin
      return model_mem[addr];
    end
    return ~addr;
  endfunction

  function automatic logic [LINE_W-1:0] model_line(input logic [ADDR_W-1:0] base);
    logic [LINE_W-1:0] line;
    int                n;
    for (n = 0; n < WORDS_PER_LINE; n++) begin
      line[n*DATA_W +: DATA_W] = model_read(base + ADDR_W'(4 * n));
    end
    return line;
  endfunction

  task automatic report_mismatch(input string what, input logic [LINE_W-1:0] expected,
                                 input logic [LINE_W-1:0] actual);
    errors++;
    $display("mismatch %s: expected %0h actual %0h", what, expected, actual);
  endtask

  task automatic report_error(input string what);
    errors++;
    $display("error: %s", what);
  endtask

  task automatic access(input req_op_t op, input logic [ADDR_W-1:0] addr,
                        input logic [DATA_W-1:0] data, input string name);
    int                set;
    int                way;
    int                w;
    int                wait_cnt;
    int                hold;
    int                log_start;
    int                val_start;
    logic              hit;
    logic              evict;
    logic [ADDR_W-1:0] base;
    logic [ADDR_W-1:0] evict_base;
    logic [LINE_W-1:0] evict_line;
    logic [DATA_W-1:0] expect_data;
    cache_resp_t       held;
    mem_req_t          m;

    if (timed_out) begin
      return;
    end
    // Predict hit, victim and writeback from the state before the access
    set  = int'((addr >> OFFSET_W) % num_sets);
    base = {addr[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
    hit  = 1'b0;
    way  = 1 - mru_m[set];
    for (w = 0; w < 2; w++) begin
      if (valid_m[w][set] && line_m[w][set] == base) begin
        hit = 1'b1;
        way = w;
      end
    end
    evict       = !hit && dirty_m[way][set];
    evict_base  = line_m[way][set];
    evict_line  = model_line(evict_base);
    expect_data = model_read(addr);
    mru_m[set]  = way;
    if (!hit) begin
      line_m[way][set]  = base;
      valid_m[way][set] = 1'b1;
      dirty_m[way][set] = 1'b0;
    end
    if (op == WRITE) begin
      model_mem[addr]   = data;
      dirty_m[way][set] = 1'b1;
    end

    log_start     = memreq_log.size();
    val_start     = memval_total;
    cachereq.op   = op;
    cachereq.addr = addr;
    cachereq.data = data;
    cachereq_val  = 1'b1;
    wait_cnt      = 0;
    while (!cachereq_rdy && wait_cnt < timeout) begin
      @(posedge clk);
      #1;
      wait_cnt++;
    end
    if (!cachereq_rdy) begin
      report_error({name, ": request not accepted before timeout"});
      timed_out = 1'b1;
      return;
    end
    @(posedge clk);
    #1;
    cachereq_val = 1'b0;
    wait_cnt     = 0;
    while (!cacheresp_val && wait_cnt < timeout) begin
      @(posedge clk);
      #1;
      wait_cnt++;
    end
    if (!cacheresp_val) begin
      report_error({name, ": no response before timeout"});
      timed_out = 1'b1;
      return;
    end

    assert (cacheresp.op == op)
      else report_mismatch({name, " op"}, LINE_W'(op), LINE_W'(cacheresp.op));
    if (op == READ) begin
      assert (cacheresp.data == expect_data)
        else report_mismatch({name, " data"}, LINE_W'(expect_data), LINE_W'(cacheresp.data));
    end
    if (hit) begin
      assert (wait_cnt == 2)
        else report_mismatch({name, " hit latency"}, LINE_W'(2), LINE_W'(wait_cnt));
      assert (memval_total == val_start)
        else report_error({name, ": memory request raised during a hit"});
    end else begin
      assert (memreq_log.size() - log_start == (evict ? 2 : 1))
        else report_mismatch({name, " memory requests"}, LINE_W'(evict ? 2 : 1),
                             LINE_W'(memreq_log.size() - log_start));
      if (evict && memreq_log.size() - log_start == 2) begin
        m = memreq_log[log_start];
        assert (m.op == MEM_WRITE)
          else report_error({name, ": first memory request is not a writeback"});
        assert (m.addr == evict_base)
          else report_mismatch({name, " writeback addr"}, LINE_W'(evict_base), LINE_W'(m.addr));
        assert (m.line == evict_line)
          else report_mismatch({name, " writeback line"}, evict_line, m.line);
      end
      if (memreq_log.size() > log_start) begin
        m = memreq_log[memreq_log.size() - 1];
        assert (m.op == MEM_READ)
          else report_error({name, ": last memory request is not a refill"});
        assert (m.addr == base)
          else report_mismatch({name, " refill addr"}, LINE_W'(base), LINE_W'(m.addr));
      end
    end

    // Occasional response back-pressure
    held = cacheresp;
    hold = (rand_below(4) == 0) ? 1 + rand_below(6) : 0;
    repeat (hold) begin
      @(posedge clk);
      #1;
      assert (cacheresp_val && cacheresp == held)
        else report_error({name, ": response changed while stalled"});
      assert (!cachereq_rdy)
        else report_error({name, ": request ready while a response is stalled"});
    end
    cacheresp_rdy = 1'b1;
    @(posedge clk);
    #1;
    cacheresp_rdy = 1'b0;
  endtask

  initial begin
    int s;
    int t;
    int w;
    int n;

    seed          = 32'had01d364;
    errors        = 0;
    timed_out     = 1'b0;
    clk           = 1'b0;
    reset         = 1'b1;
    cachereq_val  = 1'b0;
    cachereq      = '0;
    cacheresp_rdy = 1'b0;
    for (s = 0; s < num_sets; s++) begin
      mru_m[s] = 0;
      for (w = 0; w < 2; w++) begin
        line_m[w][s]  = '0;
        valid_m[w][s] = 1'b0;
        dirty_m[w][s] = 1'b0;
      end
    end
    repeat (2) @(posedge clk);
    #1;
    reset = 1'b0;
    assert (cachereq_rdy && !cacheresp_val && !memreq_val)
      else report_error("handshake outputs wrong after reset");

    for (n = 0; n < 3; n++) begin
      access(READ, pool_addr(n, 3, n), '0, "read_untouched");
    end

    // Three tags into set 3, touch the first, then one more conflict
    for (t = 0; t < 3; t++) begin
      access(WRITE, pool_addr(3, t, 1), $random(seed), "lru_fill");
    end
    access(READ, pool_addr(3, 0, 1), '0, "lru_touch");
    access(WRITE, pool_addr(3, 3, 2), $random(seed), "lru_evict");

    for (n = 0; n < 300 && !timed_out; n++) begin
      access((rand_below(2) != 0) ? WRITE : READ,
             pool_addr(rand_below(4), rand_below(4), rand_below(4)),
             $random(seed), "random");
    end

    for (s = 0; s < 4; s++) begin
      for (t = 0; t < 4; t++) begin
        for (w = 0; w < WORDS_PER_LINE; w++) begin
          access(READ, pool_addr(s, t, w), '0, "readback");
        end
      end
    end

    assert (!mem_stuck)
      else report_error("memory model response was never taken");
    $display("errors: %0d", errors);
    if (errors == 0) begin
      $display("*** TEST PASSED ***");
    end else begin
      $display("*** TEST FAILED ***");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* sim/mem_responder.sv */
/*
 * Memory model behind the cache memory port: random request ready,
 * 1 to 5 cycle response delay, line refill and writeback
 */
`timescale 1ns/1ps
`default_nettype none

module mem_responder (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  memreq_val,
  output logic                  memreq_rdy,
  input  cache_pkg::mem_req_t   memreq,
  output logic                  memresp_val,
  input  logic                  memresp_rdy,
  output cache_pkg::mem_resp_t  memresp,
  output logic                  stuck
);

  import cache_pkg::*;

  localparam int timeout = 200;

  logic [DATA_W-1:0] mem [logic [ADDR_W-1:0]];
  int                seed;
  mem_req_t          req;

  // Untouched words hold their own address inverted
  function automatic logic [DATA_W-1:0] stored_word(input logic [ADDR_W-1:0] addr);
    if (mem.exists(addr)) begin
      return mem[addr];
    end
    return ~addr;
  endfunction

  task automatic serve(input mem_req_t r);
    mem_resp_t resp;
    int        i;
    int        delay;
    int        wait_cnt;

    resp.op   = r.op;
    resp.line = '0;
    for (i = 0; i < WORDS_PER_LINE; i++) begin
      if (r.op == MEM_WRITE) begin
        mem[r.addr + ADDR_W'(4 * i)] = r.line[i*DATA_W +: DATA_W];
      end else begin
        resp.line[i*DATA_W +: DATA_W] = stored_word(r.addr + ADDR_W'(4 * i));
      end
    end
    delay = 1 + int'($unsigned($random(seed)) % 5);
    repeat (delay - 1) begin
      @(posedge clk);
      #1;
    end
    memresp     = resp;
    memresp_val = 1'b1;
    wait_cnt    = 0;
    @(negedge clk);
    while (!memresp_rdy && wait_cnt < timeout) begin
      @(negedge clk);
      wait_cnt++;
    end
    if (!memresp_rdy) begin
      $display("memory response was not taken within %0d cycles", timeout);
      stuck       = 1'b1;
      memresp_val = 1'b0;
      return;
    end
    @(posedge clk);
    #1;
    memresp_val = 1'b0;
  endtask

  initial begin
    seed        = 32'had01d364;
    stuck       = 1'b0;
    memreq_rdy  = 1'b0;
    memresp_val = 1'b0;
    memresp     = '0;
    forever begin
      // Decide at the falling edge, drive just after the rising edge
      @(negedge clk);
      if (!reset && memreq_val && memreq_rdy) begin
        req = memreq;
        @(posedge clk);
        #1;
        memreq_rdy = 1'b0;
        serve(req);
      end else begin
        @(posedge clk);
        #1;
        memreq_rdy = ($random(seed) % 2) != 0;
      end
    end
  end

endmodule

`default_nettype wire

/* verilog/blocking_cache.sv */
/*
 * Two-way set-associative write-back blocking cache with LRU
 * replacement, built from a controller and two storage blocks
 */
`timescale 1ns/1ps
`default_nettype none

module blocking_cache #(
  parameter int num_sets = 8
) (
  input  logic                     clk,
  input  logic                     reset,

  input  logic                     cachereq_val,
  output logic                     cachereq_rdy,
  input  cache_pkg::cache_req_t    cachereq,

  output logic                     cacheresp_val,
  input  logic                     cacheresp_rdy,
  output cache_pkg::cache_resp_t   cacheresp,

  output logic                     memreq_val,
  input  logic                     memreq_rdy,
  output cache_pkg::mem_req_t      memreq,

  input  logic                     memresp_val,
  output logic                     memresp_rdy,
  input  cache_pkg::mem_resp_t     memresp
);

  import cache_pkg::*;

  logic [ADDR_W-1:0]  req_addr;
  meta_cmd_t          meta_cmd;
  lookup_t            lookup;
  data_cmd_t          data_cmd;
  way_t               read_way;
  logic [DATA_W-1:0]  read_word;
  logic [LINE_W-1:0]  victim_line;

  cache_ctrl #(.num_sets(num_sets)) u_ctrl (
    .clk           (clk),
    .reset         (reset),
    .cachereq_val  (cachereq_val),
    .cachereq_rdy  (cachereq_rdy),
    .cachereq      (cachereq),
    .cacheresp_val (cacheresp_val),
    .cacheresp_rdy (cacheresp_rdy),
    .cacheresp     (cacheresp),
    .memreq_val    (memreq_val),
    .memreq_rdy    (memreq_rdy),
    .memreq        (memreq),
    .memresp_val   (memresp_val),
    .memresp_rdy   (memresp_rdy),
    .memresp       (memresp),
    .req_addr      (req_addr),
    .meta_cmd      (meta_cmd),
    .lookup        (lookup),
    .data_cmd      (data_cmd),
    .read_way      (read_way),
    .read_word     (read_word),
    .victim_line   (victim_line)
  );

  cache_meta #(.num_sets(num_sets)) u_meta (
    .clk      (clk),
    .reset    (reset),
    .req_addr (req_addr),
    .meta_cmd (meta_cmd),
    .lookup   (lookup)
  );

  cache_data #(.num_sets(num_sets)) u_data (
    .clk         (clk),
    .req_addr    (req_addr),
    .data_cmd    (data_cmd),
    .read_way    (read_way),
    .read_word   (read_word),
    .victim_line (victim_line)
  );

endmodule

`default_nettype wire

/* verilog/cache_data.sv */
/*
 * Cache data store: line storage for both ways, word or full-line
 * writes, word select and victim line read
 */
`timescale 1ns/1ps
`default_nettype none

module cache_data #(
  parameter int num_sets = 8
) (
  input  logic                           clk,
  input  logic [cache_pkg::ADDR_W-1:0]   req_addr,
  input  cache_pkg::data_cmd_t           data_cmd,
  input  cache_pkg::way_t                read_way,
  output logic [cache_pkg::DATA_W-1:0]   read_word,
  output logic [cache_pkg::LINE_W-1:0]   victim_line
);

  import cache_pkg::*;

  localparam int idx_w = $clog2(num_sets);

  logic [LINE_W-1:0]      lines [2][num_sets];
  logic [idx_w-1:0]       idx;
  logic [WORD_OFF_W-1:0]  word_off;

  assign idx      = req_addr[OFFSET_W +: idx_w];
  assign word_off = req_addr[OFFSET_W-1 -: WORD_OFF_W];

  // ---------------------------------------------------------
  // Write port
  // ---------------------------------------------------------

  always_ff @(posedge clk) begin
    if (data_cmd.wen) begin
      if (data_cmd.full_line) begin
        lines[data_cmd.way][idx] <= data_cmd.line;
      end else begin
        lines[data_cmd.way][idx][data_cmd.word_off*DATA_W +: DATA_W] <= data_cmd.word;
      end
    end
  end

  // ---------------------------------------------------------
  // Read port
  // ---------------------------------------------------------

  // Whole line feeds the writeback path
  assign victim_line = lines[read_way][idx];
  assign read_word   = victim_line[word_off*DATA_W +: DATA_W];

endmodule

`default_nettype wire

/* verilog/cache_meta.sv */
/*
 * Cache metadata store: tags, valid and dirty bits per way and one
 * LRU bit per set, with combinational hit and victim lookup
 */
`timescale 1ns/1ps
`default_nettype none

module cache_meta #(
  parameter int num_sets = 8
) (
  input  logic                           clk,
  input  logic                           reset,
  input  logic [cache_pkg::ADDR_W-1:0]   req_addr,
  input  cache_pkg::meta_cmd_t           meta_cmd,
  output cache_pkg::lookup_t             lookup
);

  import cache_pkg::*;

  localparam int idx_w = $clog2(num_sets);
  localparam int tag_w = ADDR_W - OFFSET_W - idx_w;

  logic [tag_w-1:0]          tags [2][num_sets];
  logic [1:0][num_sets-1:0]  valid_q;
  logic [1:0][num_sets-1:0]  dirty_q;
  // Most recently touched way of each set
  logic [num_sets-1:0]       mru_q;

  logic [idx_w-1:0]  idx;
  logic [tag_w-1:0]  tag;
  logic              hit0;
  logic              hit1;
  way_t              victim;

  assign idx = req_addr[OFFSET_W +: idx_w];
  assign tag = req_addr[ADDR_W-1 -: tag_w];

  // ---------------------------------------------------------
  // Updates
  // ---------------------------------------------------------

  always_ff @(posedge clk) begin
    if (reset) begin
      valid_q <= '0;
      dirty_q <= '0;
      mru_q   <= '0;
    end else begin
      if (meta_cmd.wen) begin
        valid_q[meta_cmd.way][idx] <= meta_cmd.valid;
        dirty_q[meta_cmd.way][idx] <= meta_cmd.dirty;
      end
      if (meta_cmd.lru_touch) begin
        mru_q[idx] <= meta_cmd.lru_way;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (meta_cmd.wen && meta_cmd.tag_wen) begin
      tags[meta_cmd.way][idx] <= tag;
    end
  end

  // ---------------------------------------------------------
  // Lookup
  // ---------------------------------------------------------

  assign hit0 = valid_q[0][idx] && (tags[0][idx] == tag);
  assign hit1 = valid_q[1][idx] && (tags[1][idx] == tag);

  // Replace the way that was not touched last
  assign victim = way_t'(~mru_q[idx]);

  always_comb begin
    lookup.hit          = hit0 || hit1;
    lookup.hit_way      = way_t'(hit1);
    lookup.victim_way   = victim;
    lookup.victim_dirty = dirty_q[victim][idx];
    lookup.victim_tag   = MAX_TAG_W'(tags[victim][idx]);
  end

endmodule

`default_nettype wire

/* verilog/cache_ctrl.sv */
/*
 * Cache controller FSM: latches one request, checks tags, runs
 * writeback and refill over the memory port and returns the response
 */
`timescale 1ns/1ps
`default_nettype none

module cache_ctrl #(
  parameter int num_sets = 8
) (
  input  logic                           clk,
  input  logic                           reset,

  input  logic                           cachereq_val,
  output logic                           cachereq_rdy,
  input  cache_pkg::cache_req_t          cachereq,

  output logic                           cacheresp_val,
  input  logic                           cacheresp_rdy,
  output cache_pkg::cache_resp_t         cacheresp,

  output logic                           memreq_val,
  input  logic                           memreq_rdy,
  output cache_pkg::mem_req_t            memreq,

  input  logic                           memresp_val,
  output logic                           memresp_rdy,
  input  cache_pkg::mem_resp_t           memresp,

  output logic [cache_pkg::ADDR_W-1:0]   req_addr,
  output cache_pkg::meta_cmd_t           meta_cmd,
  input  cache_pkg::lookup_t             lookup,
  output cache_pkg::data_cmd_t           data_cmd,
  output cache_pkg::way_t                read_way,
  input  logic [cache_pkg::DATA_W-1:0]   read_word,
  input  logic [cache_pkg::LINE_W-1:0]   victim_line
);

  import cache_pkg::*;

  localparam int idx_w = $clog2(num_sets);
  localparam int tag_w = ADDR_W - OFFSET_W - idx_w;

  typedef enum logic [3:0] {
    IDLE,
    TAG_CHECK,
    ACCESS,
    RESPOND,
    EVICT_REQ,
    EVICT_WAIT,
    REFILL_REQ,
    REFILL_WAIT,
    REFILL_UPDATE
  } state_t;

  state_t              state;
  state_t              state_next;
  cache_req_t          req_q;
  way_t                way_q;
  logic [DATA_W-1:0]   resp_data_q;
  logic [LINE_W-1:0]   refill_line_q;
  logic                req_fire;
  logic [idx_w-1:0]    idx;
  logic [ADDR_W-1:0]   evict_addr;
  logic [ADDR_W-1:0]   refill_addr;

  // ---------------------------------------------------------
  // State and registers
  // ---------------------------------------------------------

  assign req_fire = cachereq_val && cachereq_rdy;

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= IDLE;
      way_q <= WAY0;
    end else begin
      state <= state_next;
      // Hit way, or the LRU victim on a miss
      if (state == TAG_CHECK) begin
        way_q <= lookup.hit ? lookup.hit_way : lookup.victim_way;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (req_fire) begin
      req_q <= cachereq;
    end
    if (state == ACCESS) begin
      resp_data_q <= (req_q.op == READ) ? read_word : '0;
    end
    if (state == REFILL_WAIT && memresp_val) begin
      refill_line_q <= memresp.line;
    end
  end

  always_comb begin
    state_next = state;
    case (state)
      IDLE:          if (req_fire) state_next = TAG_CHECK;
      TAG_CHECK: begin
        if (lookup.hit) begin
          state_next = ACCESS;
        end else if (lookup.victim_dirty) begin
          state_next = EVICT_REQ;
        end else begin
          state_next = REFILL_REQ;
        end
      end
      ACCESS:        state_next = RESPOND;
      RESPOND:       if (cacheresp_rdy) state_next = IDLE;
      EVICT_REQ:     if (memreq_rdy) state_next = EVICT_WAIT;
      EVICT_WAIT:    if (memresp_val) state_next = REFILL_REQ;
      REFILL_REQ:    if (memreq_rdy) state_next = REFILL_WAIT;
      REFILL_WAIT:   if (memresp_val) state_next = REFILL_UPDATE;
      REFILL_UPDATE: state_next = ACCESS;
      default:       state_next = IDLE;
    endcase
  end

  // ---------------------------------------------------------
  // Handshakes and messages
  // ---------------------------------------------------------

  assign cachereq_rdy  = (state == IDLE);
  assign cacheresp_val = (state == RESPOND);
  assign memreq_val    = (state == EVICT_REQ) || (state == REFILL_REQ);
  assign memresp_rdy   = (state == EVICT_WAIT) || (state == REFILL_WAIT);

  assign cacheresp.op   = req_q.op;
  assign cacheresp.data = resp_data_q;

  assign idx         = req_q.addr[OFFSET_W +: idx_w];
  assign evict_addr  = {lookup.victim_tag[tag_w-1:0], idx, {OFFSET_W{1'b0}}};
  assign refill_addr = {req_q.addr[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};

  always_comb begin
    if (state == EVICT_REQ) begin
      memreq.op   = MEM_WRITE;
      memreq.addr = evict_addr;
      memreq.line = victim_line;
    end else begin
      memreq.op   = MEM_READ;
      memreq.addr = refill_addr;
      memreq.line = '0;
    end
  end

  assign req_addr = req_q.addr;
  assign read_way = way_q;

  // Storage updates in ACCESS and REFILL_UPDATE only
  always_comb begin
    meta_cmd          = '0;
    meta_cmd.way      = way_q;
    meta_cmd.lru_way  = way_q;
    data_cmd          = '0;
    data_cmd.way      = way_q;
    data_cmd.word_off = req_q.addr[OFFSET_W-1 -: WORD_OFF_W];
    data_cmd.word     = req_q.data;
    data_cmd.line     = refill_line_q;
    case (state)
      ACCESS: begin
        meta_cmd.lru_touch = 1'b1;
        if (req_q.op == WRITE) begin
          meta_cmd.wen   = 1'b1;
          meta_cmd.valid = 1'b1;
          meta_cmd.dirty = 1'b1;
          data_cmd.wen   = 1'b1;
        end
      end
      REFILL_UPDATE: begin
        meta_cmd.wen       = 1'b1;
        meta_cmd.valid     = 1'b1;
        meta_cmd.dirty     = 1'b0;
        meta_cmd.tag_wen   = 1'b1;
        data_cmd.wen       = 1'b1;
        data_cmd.full_line = 1'b1;
      end
      default: begin
      end
    endcase
  end

endmodule

`default_nettype wire

/* verilog/cache_pkg.sv */
/*
 * Cache package: widths, request and response messages, and the
 * internal command and lookup records of the two-way blocking cache
 */
`default_nettype none

package cache_pkg;

  localparam int ADDR_W         = 32;
  localparam int DATA_W         = 32;
  localparam int LINE_W         = 128;
  localparam int OFFSET_W       = 4;
  localparam int WORDS_PER_LINE = 4;
  localparam int WORD_OFF_W     = $clog2(WORDS_PER_LINE);
  // Tag width with the index at its narrowest
  localparam int MAX_TAG_W      = ADDR_W - OFFSET_W;

  typedef enum logic {READ, WRITE} req_op_t;
  typedef enum logic {MEM_READ, MEM_WRITE} mem_op_t;
  typedef enum logic {WAY0, WAY1} way_t;

  // ---------------------------------------------------------
  // External messages
  // ---------------------------------------------------------

  typedef struct packed {
    req_op_t             op;
    logic [ADDR_W-1:0]   addr;
    logic [DATA_W-1:0]   data;
  } cache_req_t;

  typedef struct packed {
    req_op_t             op;
    logic [DATA_W-1:0]   data;
  } cache_resp_t;

  typedef struct packed {
    mem_op_t             op;
    logic [ADDR_W-1:0]   addr;
    logic [LINE_W-1:0]   line;
  } mem_req_t;

  typedef struct packed {
    mem_op_t             op;
    logic [LINE_W-1:0]   line;
  } mem_resp_t;

  // ---------------------------------------------------------
  // Controller to storage records
  // ---------------------------------------------------------

  typedef struct packed {
    logic                wen;
    way_t                way;
    logic                valid;
    logic                dirty;
    logic                tag_wen;
    logic                lru_touch;
    way_t                lru_way;
  } meta_cmd_t;

  typedef struct packed {
    logic                hit;
    way_t                hit_way;
    way_t                victim_way;
    logic                victim_dirty;
    logic [MAX_TAG_W-1:0] victim_tag;
  } lookup_t;

  typedef struct packed {
    logic                  wen;
    way_t                  way;
    logic                  full_line;
    logic [WORD_OFF_W-1:0] word_off;
    logic [DATA_W-1:0]     word;
    logic [LINE_W-1:0]     line;
  } data_cmd_t;

endpackage

`default_nettype wire
